/* Makefile */
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module usb_reg_tb \
		-Mdir $(OBJ) -o usb_reg_sim

run: build
	./$(OBJ)/usb_reg_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f build.f --top-module usb_reg_tb

clean:
	rm -rf $(OBJ) sim.log

/* build.f */
hw/usb_reg_pkg.sv
hw/usb_reg_bus.sv
hw/usb_cfg_regs.sv
hw/usb_intr_ctrl.sv
hw/usb_fifo_port.sv
hw/usb_reg_top.sv
sim/tb_clk_gen.sv
sim/usb_reg_chk.sv
sim/usb_reg_mon.sv
sim/usb_reg_tb.sv

/* hw/usb_cfg_regs.sv */
/*
 * Control word and the upper part of the command word. Drives the core
 * configuration, the one-cycle send commands and the capture of the
 * endpoint and PID of the last received token.
 */
`timescale 1ns/10ps

module usb_cfg_regs
   import usb_reg_pkg::*;
(
   input  logic                     mclk,
   input  logic                     reset_n,
   input  reg_acc_t                 acc,
   input  usb_rx_evt_t              rx_evt,
   output usb_cfg_t                 cfg,
   output logic [DATA_W-1:0]        ctrl_word,
   output logic [DATA_W-1:INTR_W]   cmd_hi
);

   logic       ctrl_wr;
   logic       cmd_wr;
   logic [3:0] pid_sel;
   logic [3:0] ep_cap;
   logic [3:0] pid_cap;
   logic       send_token;
   logic       send_data;

   assign ctrl_wr = acc.stb & acc.wr & (acc.addr == REG_CTRL);
   assign cmd_wr  = acc.stb & acc.wr & (acc.addr == REG_CMD);

   //----------------------------------------------------------------------
   // Word 0, byte-enabled control storage
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
         ctrl_word <= 32'h0000_0004;
      else if (ctrl_wr)
      begin
         for (int b = 0; b < BE_W; b++)
         begin
            if (acc.be[b])
               ctrl_word[b*BYTE_W +: BYTE_W] <= acc.wdata[b*BYTE_W +: BYTE_W];
         end
      end
   end

   //----------------------------------------------------------------------
   // Word 1, PID selects and send commands
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         pid_sel    <= '0;
         send_token <= 1'b0;
         send_data  <= 1'b0;
      end
      else
      begin
         // Selects live in byte 2
         if (cmd_wr && acc.be[2])
            pid_sel <= acc.wdata[23:20];
         // Commands drop by themselves the cycle after
         send_token <= cmd_wr & acc.be[3] & acc.wdata[31];
         send_data  <= cmd_wr & acc.be[3] & acc.wdata[30];
      end
   end

   // Endpoint and PID of the last token
   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         ep_cap  <= '0;
         pid_cap <= '0;
      end
      else if (rx_evt.token_valid)
      begin
         ep_cap  <= rx_evt.ep_sel;
         pid_cap <= rx_evt.pid;
      end
   end

   // Send bits read back as the live pulse
   assign cmd_hi = {send_token, send_data, 6'b0, pid_sel, 4'b0, pid_cap, ep_cap};

   always_comb
   begin
      cfg.usb_enb       = ctrl_word[0];
      cfg.srst_n        = ~ctrl_word[1];
      cfg.phy_tx_mode   = ctrl_word[2];
      cfg.max_hms       = ctrl_word[23:16];
      cfg.token_pid_sel = pid_sel[1:0];
      cfg.data_pid_sel  = pid_sel[3:2];
      cfg.send_token    = send_token;
      cfg.send_data     = send_data;
   end

endmodule

/* hw/usb_fifo_port.sv */
/*
 * FIFO access port. Turns strobed accesses to words 5 and 6 into push
 * and pop strobes and forms the status word of word 4. Purely
 * combinational, the strobes follow the bus access strobe.
 */
`timescale 1ns/10ps

module usb_fifo_port
   import usb_reg_pkg::*;
(
   input  reg_acc_t          acc,
   input  usb_rx_evt_t       rx_evt,
   input  fifo_stat_t        tx_stat,
   input  fifo_stat_t        rx_stat,
   input  logic [BYTE_W-1:0] rx_fifo_data,
   output logic              tx_fifo_wr_en,
   output logic [BYTE_W-1:0] tx_fifo_data,
   output logic              rx_fifo_rd_en,
   output logic [DATA_W-1:0] fifo_rdata
);

   logic [DATA_W-1:0] stat_word;

   // Push only when there is room, a full FIFO drops the byte
   assign tx_fifo_wr_en = acc.stb & acc.wr & (acc.addr == REG_TXDATA) & ~tx_stat.full;
   assign tx_fifo_data  = acc.wdata[BYTE_W-1:0];

   // Pop only when something is there
   assign rx_fifo_rd_en = acc.stb & ~acc.wr & (acc.addr == REG_RXDATA) & ~rx_stat.empty;

   // Function address, occupancies and flags
   assign stat_word = {1'b0, rx_evt.token_fadr,
                       3'b0, rx_stat.occ,
                       3'b0, tx_stat.occ,
                       4'b0, rx_stat.empty, rx_stat.full, tx_stat.empty, tx_stat.full};

   assign fifo_rdata = (acc.addr == REG_RXDATA) ?
                       {{(DATA_W-BYTE_W){1'b0}}, rx_fifo_data} : stat_word;

endmodule

/* hw/usb_intr_ctrl.sv */
/*
 * Interrupt status and mask. Latches the eight event sources into
 * write-one-to-clear status bits in word 1, holds the mask of word 2
 * and raises usb_irq while any unmasked status bit is set.
 */
`timescale 1ns/10ps

module usb_intr_ctrl
   import usb_reg_pkg::*;
(
   input  logic              mclk,
   input  logic              reset_n,
   input  reg_acc_t          acc,
   input  usb_rx_evt_t       rx_evt,
   input  fifo_stat_t        tx_stat,
   input  fifo_stat_t        rx_stat,
   output logic [INTR_W-1:0] intr_stat,
   output logic [INTR_W-1:0] intr_mask,
   output logic              usb_irq
);

   logic [INTR_W-1:0] evt;
   logic [INTR_W-1:0] clr;
   logic              mask_wr;

   //----------------------------------------------------------------------
   // Event sources
   //----------------------------------------------------------------------
   always_comb
   begin
      evt                = '0;
      evt[INTR_USB_RST]  = rx_evt.usb_rst;
      evt[INTR_TOKEN]    = rx_evt.token_valid;
      evt[INTR_DDONE]    = rx_evt.fifo_ddone;
      evt[INTR_PID_ERR]  = rx_evt.pid_cs_err;
      evt[INTR_CRC5]     = rx_evt.crc5_err;
      evt[INTR_CRC16]    = rx_evt.crc16_err;
      evt[INTR_TX_OFLOW] = tx_stat.flow;
      evt[INTR_RX_UFLOW] = rx_stat.flow;
   end

   // Clear needs byte 0 of the command word
   assign clr = (acc.stb && acc.wr && acc.addr == REG_CMD && acc.be[0]) ?
                acc.wdata[INTR_W-1:0] : '0;

   assign mask_wr = acc.stb & acc.wr & (acc.addr == REG_MASK) & acc.be[0];

   //----------------------------------------------------------------------
   // Status and mask
   //----------------------------------------------------------------------
   // A new event beats a clear in the same cycle
   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
         intr_stat <= '0;
      else
         intr_stat <= (intr_stat & ~clr) | evt;
   end

   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
         intr_mask <= '0;
      else if (mask_wr)
         intr_mask <= acc.wdata[INTR_W-1:0];
   end

   assign usb_irq = |(intr_stat & intr_mask);

endmodule

/* hw/usb_reg_bus.sv */
/*
 * Register bus front end. Answers every cs with a one-cycle ack one
 * cycle later, registers the read word at the edge that raises ack and
 * hands a decoded access with its strobe to the register blocks.
 */
`timescale 1ns/10ps

module usb_reg_bus
   import usb_reg_pkg::*;
(
   input  logic              mclk,
   input  logic              reset_n,
   input  reg_req_t          req,
   input  logic [DATA_W-1:0] cfg_rdata,
   input  logic [DATA_W-1:0] intr_rdata,
   input  logic [DATA_W-1:0] fifo_rdata,
   output reg_acc_t          acc,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack
);

   reg_addr_e         word;
   logic [DATA_W-1:0] rd_word;
   logic              rd_cap;

   // Word address as a map entry
   assign word = reg_addr_e'(req.addr);

   //----------------------------------------------------------------------
   // Handshake
   //----------------------------------------------------------------------
   // Ack one cycle after cs, never twice in a row
   always_ff @(posedge mclk or negedge reset_n)
   begin
      if (!reset_n)
         reg_ack <= 1'b0;
      else
         reg_ack <= req.cs & ~reg_ack;
   end

   // Decoded access, stb coincides with ack
   assign acc.stb   = reg_ack;
   assign acc.wr    = req.wr;
   assign acc.addr  = word;
   assign acc.wdata = req.wdata;
   assign acc.be    = req.be;

   //----------------------------------------------------------------------
   // Read path
   //----------------------------------------------------------------------
   // Group select, each block already picked its own word
   always_comb
   begin
      case (word)
         REG_CTRL, REG_FRAME:    rd_word = cfg_rdata;
         REG_CMD, REG_MASK:      rd_word = intr_rdata;
         REG_STATUS, REG_RXDATA: rd_word = fifo_rdata;
         default:                rd_word = '0;
      endcase
   end

   // Capture before the pop strobe moves the rx FIFO
   assign rd_cap = req.cs & ~req.wr & ~reg_ack;

   always_ff @(posedge mclk)
   begin
      if (rd_cap)
         reg_rdata <= rd_word;
   end

endmodule

/* hw/usb_reg_pkg.sv */
/*
 * Shared widths, register map, interrupt bit positions and bus structs
 * for the USB 1.1 function core register block. Every RTL module of the
 * block pulls this in with a wildcard import in its header.
 */
package usb_reg_pkg;

   //----------------------------------------------------------------------
   // Widths
   //----------------------------------------------------------------------
   localparam int DATA_W = 32;   // Register bus data
   localparam int ADDR_W = 4;    // Word address, 16 words
   localparam int BE_W   = 4;    // One enable per byte lane
   localparam int INTR_W = 8;    // Interrupt status and mask
   localparam int OCC_W  = 5;    // FIFO occupancy count
   localparam int BYTE_W = 8;    // FIFO payload and byte lane width

   // Word map, words 7 to 15 are unmapped
   typedef enum logic [ADDR_W-1:0] {
      REG_CTRL   = 4'd0,
      REG_CMD    = 4'd1,
      REG_MASK   = 4'd2,
      REG_FRAME  = 4'd3,
      REG_STATUS = 4'd4,
      REG_TXDATA = 4'd5,
      REG_RXDATA = 4'd6
   } reg_addr_e;

   // Interrupt status bit positions in word 1
   localparam int INTR_USB_RST  = 0;
   localparam int INTR_TOKEN    = 1;
   localparam int INTR_DDONE    = 2;
   localparam int INTR_PID_ERR  = 3;
   localparam int INTR_CRC5     = 4;
   localparam int INTR_CRC16    = 5;
   localparam int INTR_TX_OFLOW = 6;
   localparam int INTR_RX_UFLOW = 7;

   //----------------------------------------------------------------------
   // Bus request from the master, held stable while cs is high
   //----------------------------------------------------------------------
   typedef struct packed {
      logic              cs;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   // Decoded access, stb marks the single ack cycle
   typedef struct packed {
      logic              stb;
      logic              wr;
      reg_addr_e         addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_acc_t;

   // Configuration toward the protocol engine and PHY
   typedef struct packed {
      logic              usb_enb;
      logic              srst_n;
      logic              phy_tx_mode;
      logic [7:0]        max_hms;
      logic [1:0]        token_pid_sel;
      logic [1:0]        data_pid_sel;
      logic              send_token;
      logic              send_data;
   } usb_cfg_t;

   // Receive side events and token fields
   typedef struct packed {
      logic              token_valid;
      logic              fifo_ddone;
      logic [6:0]        token_fadr;
      logic [3:0]        pid;
      logic [3:0]        ep_sel;
      logic              usb_rst;
      logic              pid_cs_err;
      logic              crc5_err;
      logic              crc16_err;
   } usb_rx_evt_t;

   // Status of one FIFO, flow is overflow on tx and underflow on rx
   typedef struct packed {
      logic [OCC_W-1:0]  occ;
      logic              full;
      logic              empty;
      logic              flow;
   } fifo_stat_t;

endpackage

/* hw/usb_reg_top.sv */
/*
 * Top of the USB function core register block. Connects the bus front
 * end to the config, interrupt and FIFO blocks and picks the word of
 * each read group by address.
 */
`timescale 1ns/10ps

module usb_reg_top
   import usb_reg_pkg::*;
(
   input  logic              mclk,
   input  logic              reset_n,
   input  reg_req_t          req,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack,
   input  logic [DATA_W-1:0] frm_nat,
   input  usb_rx_evt_t       rx_evt,
   input  fifo_stat_t        tx_stat,
   input  fifo_stat_t        rx_stat,
   input  logic [BYTE_W-1:0] rx_fifo_data,
   output usb_cfg_t          cfg,
   output logic              tx_fifo_wr_en,
   output logic [BYTE_W-1:0] tx_fifo_data,
   output logic              rx_fifo_rd_en,
   output logic              usb_irq
);

   reg_acc_t                acc;
   logic [DATA_W-1:0]       cfg_rdata;
   logic [DATA_W-1:0]       intr_rdata;
   logic [DATA_W-1:0]       fifo_rdata;
   logic [DATA_W-1:0]       ctrl_word;
   logic [DATA_W-1:INTR_W]  cmd_hi;
   logic [INTR_W-1:0]       intr_stat;
   logic [INTR_W-1:0]       intr_mask;

   //----------------------------------------------------------------------
   // Read groups
   //----------------------------------------------------------------------
   // Words 0 and 3
   assign cfg_rdata  = (acc.addr == REG_FRAME) ? frm_nat : ctrl_word;
   // Words 1 and 2
   assign intr_rdata = (acc.addr == REG_MASK) ?
                       {{(DATA_W-INTR_W){1'b0}}, intr_mask} : {cmd_hi, intr_stat};

   usb_reg_bus u_bus (
      .mclk       (mclk),
      .reset_n    (reset_n),
      .req        (req),
      .cfg_rdata  (cfg_rdata),
      .intr_rdata (intr_rdata),
      .fifo_rdata (fifo_rdata),
      .acc        (acc),
      .reg_rdata  (reg_rdata),
      .reg_ack    (reg_ack)
   );

   usb_cfg_regs u_cfg (
      .mclk      (mclk),
      .reset_n   (reset_n),
      .acc       (acc),
      .rx_evt    (rx_evt),
      .cfg       (cfg),
      .ctrl_word (ctrl_word),
      .cmd_hi    (cmd_hi)
   );

   usb_intr_ctrl u_intr (
      .mclk      (mclk),
      .reset_n   (reset_n),
      .acc       (acc),
      .rx_evt    (rx_evt),
      .tx_stat   (tx_stat),
      .rx_stat   (rx_stat),
      .intr_stat (intr_stat),
      .intr_mask (intr_mask),
      .usb_irq   (usb_irq)
   );

   usb_fifo_port u_fifo (
      .acc           (acc),
      .rx_evt        (rx_evt),
      .tx_stat       (tx_stat),
      .rx_stat       (rx_stat),
      .rx_fifo_data  (rx_fifo_data),
      .tx_fifo_wr_en (tx_fifo_wr_en),
      .tx_fifo_data  (tx_fifo_data),
      .rx_fifo_rd_en (rx_fifo_rd_en),
      .fifo_rdata    (fifo_rdata)
   );

endmodule

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset source. Runs mclk at a 100 ns period and
 * holds reset_n low for the first five rising edges.
 */
`timescale 1ns/10ps

module tb_clk_gen
(
   output logic mclk,
   output logic reset_n
);

   // 50 ns half period
   initial
   begin
      mclk = 1'b0;
      forever #50 mclk = ~mclk;
   end

   initial
   begin
      reset_n = 1'b0;
      repeat (5) @(posedge mclk);
      reset_n <= 1'b1;
   end

endmodule

/* sim/usb_reg_chk.sv */
/*
 * Concurrent assertions on the register bus handshake and the one-cycle
 * send commands. Bound into the bus front end and the config block,
 * each instance ties the side it cannot see to zero.
 */
`timescale 1ns/10ps

module usb_reg_chk
(
   input logic mclk,
   input logic reset_n,
   input logic cs,
   input logic ack,
   input logic send_token,
   input logic send_data
);

   // Ack is a single cycle
   a_ack_single: assert property (@(posedge mclk) disable iff (!reset_n)
      ack |=> !ack)
      else $error("reg_ack high for two cycles in a row");

   // New cs answered on the next cycle
   a_ack_follows_cs: assert property (@(posedge mclk) disable iff (!reset_n)
      (cs && !ack) |=> ack)
      else $error("reg_ack missing one cycle after cs");

   //-------------------------------------------------------------------
   // Send commands
   //-------------------------------------------------------------------
   a_send_token_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
      send_token |=> !send_token)
      else $error("send_token longer than one cycle");

   a_send_data_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
      send_data |=> !send_data)
      else $error("send_data longer than one cycle");

endmodule

// Handshake side
bind usb_reg_bus usb_reg_chk bus_chk (
   .mclk       (mclk),
   .reset_n    (reset_n),
   .cs         (req.cs),
   .ack        (reg_ack),
   .send_token (1'b0),
   .send_data  (1'b0)
);

// Command side
bind usb_cfg_regs usb_reg_chk cmd_chk (
   .mclk       (mclk),
   .reset_n    (reset_n),
   .cs         (1'b0),
   .ack        (1'b0),
   .send_token (send_token),
   .send_data  (send_data)
);

/* sim/usb_reg_mon.sv */
/*
 * Monitor and reference model of the register block. Tracks every
 * register from the bus requests and events it sees, then compares the
 * DUT outputs on each falling edge and the read data at each ack.
 */
`timescale 1ns/10ps

module usb_reg_mon
   import usb_reg_pkg::*;
(
   input  logic              mclk,
   input  logic              reset_n,
   input  reg_req_t          req,
   input  logic [DATA_W-1:0] reg_rdata,
   input  logic              reg_ack,
   input  logic [DATA_W-1:0] frm_nat,
   input  usb_rx_evt_t       rx_evt,
   input  fifo_stat_t        tx_stat,
   input  fifo_stat_t        rx_stat,
   input  logic [BYTE_W-1:0] rx_fifo_data,
   input  usb_cfg_t          cfg,
   input  logic              tx_fifo_wr_en,
   input  logic [BYTE_W-1:0] tx_fifo_data,
   input  logic              rx_fifo_rd_en,
   input  logic              usb_irq,
   output int                errors
);

   logic              m_ack;
   logic [DATA_W-1:0] m_ctrl;
   logic [3:0]        m_pid_sel;
   logic [3:0]        m_ep;
   logic [3:0]        m_pid;
   logic [INTR_W-1:0] m_stat;
   logic [INTR_W-1:0] m_mask;
   logic              m_send_t;
   logic              m_send_d;
   logic [DATA_W-1:0] m_rdata;

   initial errors = 0;

   // Expected read word from the model state of this cycle
   function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
      case (addr)
         4'd0:    return m_ctrl;
         4'd1:    return {m_send_t, m_send_d, 6'b0, m_pid_sel, 4'b0, m_pid, m_ep, m_stat};
         4'd2:    return {24'b0, m_mask};
         4'd3:    return frm_nat;
         4'd4:    return {1'b0, rx_evt.token_fadr, 3'b0, rx_stat.occ, 3'b0, tx_stat.occ,
                          4'b0, rx_stat.empty, rx_stat.full, tx_stat.empty, tx_stat.full};
         4'd6:    return {24'b0, rx_fifo_data};
         default: return '0;
      endcase
   endfunction

   // Event sources in status bit order
   function automatic logic [INTR_W-1:0] event_bits();
      logic [INTR_W-1:0] e;
      e                = '0;
      e[INTR_USB_RST]  = rx_evt.usb_rst;
      e[INTR_TOKEN]    = rx_evt.token_valid;
      e[INTR_DDONE]    = rx_evt.fifo_ddone;
      e[INTR_PID_ERR]  = rx_evt.pid_cs_err;
      e[INTR_CRC5]     = rx_evt.crc5_err;
      e[INTR_CRC16]    = rx_evt.crc16_err;
      e[INTR_TX_OFLOW] = tx_stat.flow;
      e[INTR_RX_UFLOW] = rx_stat.flow;
      return e;
   endfunction

   //-------------------------------------------------------------------
   // Reference model
   //-------------------------------------------------------------------
   always @(posedge mclk or negedge reset_n)
   begin : model
      logic              wr_acc;
      logic [INTR_W-1:0] clr;
      if (!reset_n)
      begin
         m_ack     = 1'b0;
         m_ctrl    = 32'h0000_0004;
         m_pid_sel = '0;
         m_ep      = '0;
         m_pid     = '0;
         m_stat    = '0;
         m_mask    = '0;
         m_send_t  = 1'b0;
         m_send_d  = 1'b0;
         m_rdata   = '0;
      end
      else
      begin
         // Read word taken at the edge that raises ack
         if (req.cs && !req.wr && !m_ack)
            m_rdata = read_word(req.addr);
         wr_acc = m_ack && req.wr;
         clr    = '0;
         if (wr_acc && req.addr == 4'd0)
         begin
            for (int b = 0; b < BE_W; b++)
            begin
               if (req.be[b])
                  m_ctrl[b*8 +: 8] = req.wdata[b*8 +: 8];
            end
         end
         if (wr_acc && req.addr == 4'd1 && req.be[2])
            m_pid_sel = req.wdata[23:20];
         if (wr_acc && req.addr == 4'd1 && req.be[0])
            clr = req.wdata[7:0];
         if (wr_acc && req.addr == 4'd2 && req.be[0])
            m_mask = req.wdata[7:0];
         // Set beats clear
         m_stat = (m_stat & ~clr) | event_bits();
         if (rx_evt.token_valid)
         begin
            m_ep  = rx_evt.ep_sel;
            m_pid = rx_evt.pid;
         end
         m_send_t = wr_acc && req.addr == 4'd1 && req.be[3] && req.wdata[31];
         m_send_d = wr_acc && req.addr == 4'd1 && req.be[3] && req.wdata[30];
         m_ack    = req.cs && !m_ack;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
      end
   endtask

   //-------------------------------------------------------------------
   // Comparisons, mid cycle
   //-------------------------------------------------------------------
   always @(negedge mclk)
   begin : compare
      logic exp_wr;
      logic exp_rd;
      if (reset_n)
      begin
         exp_wr = m_ack && req.wr && req.addr == 4'd5 && !tx_stat.full;
         exp_rd = m_ack && !req.wr && req.addr == 4'd6 && !rx_stat.empty;
         check_val("reg_ack", 32'(reg_ack), 32'(m_ack));
         if (m_ack && !req.wr)
            check_val("reg_rdata", reg_rdata, m_rdata);
         check_val("cfg.usb_enb", 32'(cfg.usb_enb), 32'(m_ctrl[0]));
         check_val("cfg.srst_n", 32'(cfg.srst_n), 32'(!m_ctrl[1]));
         check_val("cfg.phy_tx_mode", 32'(cfg.phy_tx_mode), 32'(m_ctrl[2]));
         check_val("cfg.max_hms", 32'(cfg.max_hms), 32'(m_ctrl[23:16]));
         check_val("cfg.token_pid_sel", 32'(cfg.token_pid_sel), 32'(m_pid_sel[1:0]));
         check_val("cfg.data_pid_sel", 32'(cfg.data_pid_sel), 32'(m_pid_sel[3:2]));
         check_val("cfg.send_token", 32'(cfg.send_token), 32'(m_send_t));
         check_val("cfg.send_data", 32'(cfg.send_data), 32'(m_send_d));
         check_val("usb_irq", 32'(usb_irq), 32'(|(m_stat & m_mask)));
         check_val("tx_fifo_wr_en", 32'(tx_fifo_wr_en), 32'(exp_wr));
         if (exp_wr)
            check_val("tx_fifo_data", 32'(tx_fifo_data), 32'(req.wdata[7:0]));
         check_val("rx_fifo_rd_en", 32'(rx_fifo_rd_en), 32'(exp_rd));
      end
   end

endmodule

/* sim/usb_reg_tb.sv */
/*
 * Top testbench of the USB register block. Drives random bus accesses,
 * events and FIFO status from a 16-bit LFSR, leaves all comparing to
 * the monitor and prints one line per test and a closing summary.
 */
`timescale 1ns/10ps

module usb_reg_tb
   import usb_reg_pkg::*;
();

   localparam int N_TESTS      = 6;
   localparam int ITERS        = 10;
   localparam int CYC_PER_ITER = 20;    // Worst iteration, five accesses
   localparam int MAX_CYCLES   = N_TESTS * ITERS * CYC_PER_ITER + 100;

   logic              mclk;
   logic              reset_n;
   reg_req_t          req;
   logic [DATA_W-1:0] reg_rdata;
   logic              reg_ack;
   logic [DATA_W-1:0] frm_nat;
   usb_rx_evt_t       rx_evt;
   fifo_stat_t        tx_stat;
   fifo_stat_t        rx_stat;
   logic [BYTE_W-1:0] rx_fifo_data;
   usb_cfg_t          cfg;
   logic              tx_fifo_wr_en;
   logic [BYTE_W-1:0] tx_fifo_data;
   logic              rx_fifo_rd_en;
   logic              usb_irq;
   int                errors;
   int                cycles = 0;
   int                test_num = 0;
   int                n_ok = 0;
   int                n_bad = 0;
   logic [15:0]       lfsr = 16'd27223;

   tb_clk_gen clk0 (.mclk(mclk), .reset_n(reset_n));

   usb_reg_top dut0 (
      .mclk          (mclk),
      .reset_n       (reset_n),
      .req           (req),
      .reg_rdata     (reg_rdata),
      .reg_ack       (reg_ack),
      .frm_nat       (frm_nat),
      .rx_evt        (rx_evt),
      .tx_stat       (tx_stat),
      .rx_stat       (rx_stat),
      .rx_fifo_data  (rx_fifo_data),
      .cfg           (cfg),
      .tx_fifo_wr_en (tx_fifo_wr_en),
      .tx_fifo_data  (tx_fifo_data),
      .rx_fifo_rd_en (rx_fifo_rd_en),
      .usb_irq       (usb_irq)
   );

   usb_reg_mon mon0 (.*);

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   //-------------------------------------------------------------------
   // Stimulus tasks
   //-------------------------------------------------------------------
   task automatic bus_access(input logic wr, input logic [3:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
      @(posedge mclk);
      req <= '{cs: 1'b1, wr: wr, addr: addr, wdata: wdata, be: be};
      do
         @(negedge mclk);
      while (!reg_ack);
      @(posedge mclk);
      req <= '0;
   endtask

   // Lines up with the ack cycle of a bus_access started alongside
   task automatic pulse_events();
      @(posedge mclk);
      @(posedge mclk);
      rx_evt.usb_rst     <= 1'(rand_bits(1));
      rx_evt.token_valid <= 1'(rand_bits(1));
      rx_evt.fifo_ddone  <= 1'(rand_bits(1));
      rx_evt.pid_cs_err  <= 1'(rand_bits(1));
      rx_evt.crc5_err    <= 1'(rand_bits(1));
      rx_evt.crc16_err   <= 1'(rand_bits(1));
      tx_stat.flow       <= 1'(rand_bits(1));
      rx_stat.flow       <= 1'(rand_bits(1));
      @(posedge mclk);
      rx_evt.usb_rst     <= 1'b0;
      rx_evt.token_valid <= 1'b0;
      rx_evt.fifo_ddone  <= 1'b0;
      rx_evt.pid_cs_err  <= 1'b0;
      rx_evt.crc5_err    <= 1'b0;
      rx_evt.crc16_err   <= 1'b0;
      tx_stat.flow       <= 1'b0;
      rx_stat.flow       <= 1'b0;
   endtask

   // Token fields and FIFO levels, token_valid for one cycle
   task automatic drive_token();
      @(posedge mclk);
      rx_evt.token_valid <= 1'(rand_bits(1));
      rx_evt.pid         <= 4'(rand_bits(4));
      rx_evt.ep_sel      <= 4'(rand_bits(4));
      rx_evt.token_fadr  <= 7'(rand_bits(7));
      tx_stat.occ        <= 5'(rand_bits(5));
      tx_stat.full       <= 1'(rand_bits(1));
      tx_stat.empty      <= 1'(rand_bits(1));
      rx_stat.occ        <= 5'(rand_bits(5));
      rx_stat.full       <= 1'(rand_bits(1));
      rx_stat.empty      <= 1'(rand_bits(1));
      @(posedge mclk);
      rx_evt.token_valid <= 1'b0;
   endtask

   // Let trailing pulses reach the monitor, then score the test
   task automatic finish_test(input string name, input int errs_before);
      repeat (3) @(posedge mclk);
      test_num++;
      if (errors == errs_before)
      begin
         n_ok++;
         $display("Test %0d %s: ok", test_num, name);
      end
      else
      begin
         n_bad++;
         $display("Test %0d %s: %0d mismatches", test_num, name, errors - errs_before);
      end
   endtask

   //-------------------------------------------------------------------
   // Run limit
   //-------------------------------------------------------------------
   always @(posedge mclk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: no end of run after %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial
   begin : stimulus
      int e0;
      req          = '0;
      rx_evt       = '0;
      tx_stat      = '0;
      rx_stat      = '0;
      frm_nat      = '0;
      rx_fifo_data = '0;
      wait (reset_n === 1'b1);
      @(posedge mclk);

      // Words 0 and 2 with byte enables, unmapped words
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         bus_access(1'b1, 4'd0, rand_bits(32), 4'(rand_bits(4)));
         bus_access(1'b0, 4'd0, '0, '0);
         bus_access(1'b1, 4'd2, rand_bits(32), 4'(rand_bits(4)));
         bus_access(1'b0, 4'd2, '0, '0);
         bus_access(1'b0, 4'(7 + rand_bits(4) % 9), '0, '0);
      end
      finish_test("ctrl and mask readback", e0);

      // Send commands and PID selects
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         bus_access(1'b1, 4'd1, rand_bits(32), 4'(rand_bits(4)) | 4'b1100);
         bus_access(1'b0, 4'd1, '0, '0);
      end
      finish_test("send commands", e0);

      // Events against clears and masks
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         bus_access(1'b1, 4'd2, rand_bits(32), 4'b0001);
         fork
            bus_access(1'b1, 4'd1, rand_bits(32), 4'b0001);
            pulse_events();
         join
         bus_access(1'b0, 4'd1, '0, '0);
      end
      finish_test("interrupt status", e0);

      // Token capture and status word
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         drive_token();
         bus_access(1'b0, 4'd1, '0, '0);
         bus_access(1'b0, 4'd4, '0, '0);
      end
      finish_test("token capture and status", e0);

      // Transmit push against full
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         @(posedge mclk);
         tx_stat.full <= 1'(rand_bits(1));
         bus_access(1'b1, 4'd5, rand_bits(32), 4'(rand_bits(4)));
      end
      finish_test("tx FIFO push", e0);

      // Receive pop against empty, frame number
      e0 = errors;
      for (int i = 0; i < ITERS; i++)
      begin
         @(posedge mclk);
         rx_stat.empty <= 1'(rand_bits(1));
         rx_fifo_data  <= 8'(rand_bits(8));
         frm_nat       <= rand_bits(32);
         bus_access(1'b0, 4'd6, '0, '0);
         bus_access(1'b0, 4'd3, '0, '0);
      end
      finish_test("rx FIFO pop and frame", e0);

      $display("Summary: %0d tests, %0d ok, %0d with mismatches, %0d errors",
               test_num, n_ok, n_bad, errors);
      if (errors == 0 && n_bad == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
